//--- bench/l2_cases.txt
# grp port(0 ic,1 dc) op(0 rd,1 wr,2 idx_inv,3 idx_wb_inv,4 hit_wb_inv) addr wdata
# src(0 none,1 memory rule,2 exp) exp mem_writes mem_reads (f = any)
1 0 0 00000500 00000000 1 00000000 f f
1 1 0 00000600 00000000 1 00000000 f f
2 0 0 00000504 00000000 1 00000000 f f
2 1 0 00000608 00000000 1 00000000 f f
3 1 0 00000100 00000000 1 00000000 0 1
4 1 0 00000100 00000000 1 00000000 0 0
5 1 1 00000104 11111111 0 00000000 0 0
6 1 0 00000104 00000000 2 11111111 0 0
7 0 1 00000210 22222222 0 00000000 0 1
8 0 0 0000021C 00000000 1 00000000 0 0
9 1 1 00001020 A0000001 0 00000000 0 1
10 1 1 00002020 A0000002 0 00000000 0 1
11 1 1 00003020 A0000003 0 00000000 0 1
12 1 1 00004020 A0000004 0 00000000 0 1
13 1 1 00005020 A0000005 0 00000000 1 1
14 1 0 00001020 00000000 2 A0000001 f f
15 1 0 00002020 00000000 2 A0000002 f f
16 1 0 00003020 00000000 2 A0000003 f f
17 1 0 00004020 00000000 2 A0000004 f f
18 1 0 00005020 00000000 2 A0000005 f f
19 1 1 00006030 33333333 0 00000000 0 1
20 1 3 00000030 00000000 0 00000000 1 0
21 1 0 00006030 00000000 2 33333333 0 1
22 1 1 00006034 44444444 0 00000000 0 0
23 1 2 00000030 00000000 0 00000000 0 0
24 1 0 00006034 00000000 1 00000000 0 1
25 1 4 00007030 00000000 0 00000000 0 0
26 0 0 00000600 00000000 1 00000000 f f
26 1 0 00000504 00000000 1 00000000 f f

//--- sim.f
+incdir+src
src/l2_cache_pkg.sv
src/l2_mem_pkg.sv
src/l2_port_arbiter.sv
src/l2_plru.sv
src/l2_array.sv
src/l2_main_fsm.sv
src/l2_top.sv
bench/l2_properties.sv
bench/tb_l2.sv

//--- Bender.yml
package:
  name: l2_cache

sources:
  - include_dirs:
      - src
    files:
      - src/l2_cache_pkg.sv
      - src/l2_mem_pkg.sv
      - src/l2_port_arbiter.sv
      - src/l2_plru.sv
      - src/l2_array.sv
      - src/l2_main_fsm.sv
      - src/l2_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/l2_properties.sv
      - bench/tb_l2.sv

//--- bench/tb_l2.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module tb_l2;

    localparam int MAX_CASES = 64;

    logic clk;
    logic rstn;
    logic ic_req, dc_req, ic_ack, dc_ack;
    l2_cache_pkg::l2_req_t ic_in, dc_in;
    l2_cache_pkg::l2_rsp_t ic_rsp, dc_rsp;
    logic mem_req, mem_ack;
    l2_mem_pkg::mem_req_t mem_out;
    l2_mem_pkg::mem_rsp_t mem_in;

    // case table
    int          n_cases;
    int          c_grp [MAX_CASES];
    int          c_port [MAX_CASES];
    int          c_op [MAX_CASES];
    logic [31:0] c_addr [MAX_CASES];
    logic [31:0] c_wdata [MAX_CASES];
    int          c_src [MAX_CASES];
    logic [31:0] c_exp [MAX_CASES];
    logic [3:0]  c_mw [MAX_CASES];   // f = any
    logic [3:0]  c_mr [MAX_CASES];

    logic [`L2_LINE_W-1:0] mem_q [logic [`L2_TAG_W+`L2_INDEX_W-1:0]];
    int       wr_count, rd_count, errors, limit;
    longint   cycle_cnt;
    int unsigned lcg_state;
    logic     last_dc;   // last granted port

    l2_top dut0 (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (limit > 0);
        while (cycle_cnt < limit)
            @(posedge clk);
        $display("timeout: no progress after %0d cycles", limit);
        $display("errors: %0d", errors + 1);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % 4) + 1;
    endfunction

    // initial memory content from the byte address rule
    function automatic logic [`L2_LINE_W-1:0] read_line(logic [27:0] laddr);
        logic [`L2_LINE_W-1:0] line;
        if (mem_q.exists(laddr))
            return mem_q[laddr];
        for (int i = 0; i < 4; i++)
            line[i*32 +: 32] = {laddr, i[1:0], 2'b00} ^ 32'hA5A5A5A5;
        return line;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////
    always begin
        int dly;
        @(posedge clk);
        if (rstn && mem_req && !mem_ack) begin
            dly = next_delay();
            repeat (dly - 1) @(posedge clk);
            if (mem_out.write) begin
                mem_q[mem_out.addr] = mem_out.data;
                wr_count++;
            end else begin
                mem_in.data <= read_line(mem_out.addr);
                rd_count++;
            end
            mem_ack <= 1'b1;
            do @(posedge clk); while (mem_req);
            mem_ack <= 1'b0;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got)
        else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // one full four-phase transaction on a port
    task automatic run_port(input int port, input int op, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int lat, output longint ack_cyc);
        l2_cache_pkg::l2_req_t pl;
        int edges;
        pl.op    = l2_cache_pkg::l2_op_e'(op);
        pl.addr  = addr;
        pl.wdata = wdata;
        edges    = 0;
        @(posedge clk);
        if (port == 0) begin
            ic_req <= 1'b1;
            ic_in  <= pl;
        end else begin
            dc_req <= 1'b1;
            dc_in  <= pl;
        end
        do begin
            @(posedge clk);
            edges++;
        end while (!(port == 0 ? ic_ack : dc_ack));
        lat     = edges - 1; // first edge only forwards req
        ack_cyc = cycle_cnt;
        rdata   = (port == 0) ? ic_rsp.rdata : dc_rsp.rdata;
        if (port == 0)
            ic_req <= 1'b0;
        else
            dc_req <= 1'b0;
        do @(posedge clk); while (port == 0 ? ic_ack : dc_ack);
    endtask

    task automatic check_read(input int i, input logic [31:0] got);
        logic [31:0] exp;
        if (c_src[i] == 0)
            return;
        exp = (c_src[i] == 1) ? ({c_addr[i][31:2], 2'b00} ^ 32'hA5A5A5A5) : c_exp[i];
        check_value(c_port[i] == 0 ? "ic_rsp.rdata" : "dc_rsp.rdata", exp, got);
    endtask

    task automatic load_cases();
        int fd, n;
        string line;
        fd = $fopen("bench/l2_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file");
            errors++;
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() < 3 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%d %d %d %h %h %d %h %h %h", c_grp[n_cases],
                            c_port[n_cases], c_op[n_cases], c_addr[n_cases],
                            c_wdata[n_cases], c_src[n_cases], c_exp[n_cases],
                            c_mw[n_cases], c_mr[n_cases]);
                if (n == 9)
                    n_cases++;
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] rd_a, rd_b;
        int lat_a, lat_b, wr0, rd0, i;
        longint ack_a, ack_b;
        logic win_dc, exp_dc;
        clk = 1'b0;
        rstn = 1'b0;
        ic_req = 1'b0;
        dc_req = 1'b0;
        ic_in = '0;
        dc_in = '0;
        mem_ack = 1'b0;
        mem_in = '0;
        cycle_cnt = 0;
        wr_count = 0;
        rd_count = 0;
        errors = 0;
        limit = 0;
        n_cases = 0;
        lcg_state = 35;
        last_dc = 1'b0;
        load_cases();
        limit = n_cases * 40;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            assert (!ic_ack && !dc_ack && !mem_req)
            else begin
                $display("an ack or mem_req was high after reset");
                errors++;
            end
        end
        i = 0;
        while (i < n_cases) begin
            if (i + 1 < n_cases && c_grp[i + 1] == c_grp[i]) begin
                // both ports at once
                fork
                    run_port(c_port[i], c_op[i], c_addr[i], c_wdata[i], rd_a, lat_a, ack_a);
                    run_port(c_port[i + 1], c_op[i + 1], c_addr[i + 1], c_wdata[i + 1],
                             rd_b, lat_b, ack_b);
                join
                check_read(i, rd_a);
                check_read(i + 1, rd_b);
                win_dc = (ack_a < ack_b) ? (c_port[i] == 1) : (c_port[i + 1] == 1);
                exp_dc = !last_dc;
                assert (win_dc == exp_dc)
                else begin
                    $display("[FAIL] %0t grant winner expected %0d got %0d",
                             $time, exp_dc, win_dc);
                    errors++;
                end
                last_dc = !win_dc; // loser is granted last
                i += 2;
            end else begin
                wr0 = wr_count;
                rd0 = rd_count;
                run_port(c_port[i], c_op[i], c_addr[i], c_wdata[i], rd_a, lat_a, ack_a);
                check_read(i, rd_a);
                if (c_mw[i] != 4'hf)
                    check_value("mem writes", c_mw[i], wr_count - wr0);
                if (c_mr[i] != 4'hf)
                    check_value("mem reads", c_mr[i], rd_count - rd0);
                if (c_op[i] == 0 && c_mw[i] == 0 && c_mr[i] == 0)
                    check_value("hit latency", 2, lat_a);
                last_dc = (c_port[i] == 1);
                i++;
            end
        end
        assert (wr_count > 0)
        else begin
            $display("no writeback reached memory");
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/l2_properties.sv
`timescale 1ns/1ps
`default_nettype none

module l2_properties (
    input wire logic                    clk,
    input wire logic                    rstn,
    input wire logic                    ic_req,
    input wire logic                    ic_ack,
    input wire logic                    dc_req,
    input wire logic                    dc_ack,
    input wire logic                    mem_req,
    input wire logic                    mem_ack,
    input wire l2_mem_pkg::mem_req_t    mem_out,
    input wire l2_cache_pkg::l2_state_e state
);

    // four-phase rules on both ports
    ic_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(ic_ack) |-> ic_req) else $error("ic_ack rose without ic_req");
    dc_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(dc_ack) |-> dc_req) else $error("dc_ack rose without dc_req");
    ic_req_held: assert property (@(posedge clk) disable iff (!rstn)
        ic_req && !ic_ack |=> ic_req) else $error("ic_req fell before ic_ack");
    dc_req_held: assert property (@(posedge clk) disable iff (!rstn)
        dc_req && !dc_ack |=> dc_req) else $error("dc_req fell before dc_ack");

    mem_out_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_ack |=> $stable(mem_out)) else $error("mem_out changed in transfer");

    one_ack: assert property (@(posedge clk) disable iff (!rstn)
        !(ic_ack && dc_ack)) else $error("both port acks high");

    // memory handshake fully closed before the controller goes idle
    mem_closed_in_idle: assert property (@(posedge clk) disable iff (!rstn)
        state == l2_cache_pkg::S_IDLE |-> !mem_ack)
        else $error("mem_ack high while the controller is idle");

endmodule

bind l2_top l2_properties props0 (
    .clk     (clk),
    .rstn    (rstn),
    .ic_req  (ic_req),
    .ic_ack  (ic_ack),
    .dc_req  (dc_req),
    .dc_ack  (dc_ack),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .mem_out (mem_out),
    .state   (fsm0.state_q)
);

`default_nettype wire

//--- src/l2_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module l2_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ic_req,
    input  l2_cache_pkg::l2_req_t ic_in,
    output logic                  ic_ack,
    output l2_cache_pkg::l2_rsp_t ic_rsp,
    input  logic                  dc_req,
    input  l2_cache_pkg::l2_req_t dc_in,
    output logic                  dc_ack,
    output l2_cache_pkg::l2_rsp_t dc_rsp,
    output logic                  mem_req,
    output l2_mem_pkg::mem_req_t  mem_out,
    input  logic                  mem_ack,
    input  l2_mem_pkg::mem_rsp_t  mem_in
);

    logic                    sel_req, sel_ack;
    l2_cache_pkg::l2_req_t   sel_in;
    l2_cache_pkg::l2_rsp_t   rsp;

    logic [`L2_INDEX_W-1:0]  index;
    logic [`L2_TAG_W-1:0]    tag_in, tag_out;
    logic [`L2_WAY_W-1:0]    way_sel, use_way, victim_way;
    logic [`L2_WAYS-1:0]     data_we, valid_clr, hit, valid_ways;
    logic [`L2_OFFSET_W-1:0] word_off;
    logic [`L2_LINE_W-1:0]   line_in, line_out;
    logic [`L2_WORD_W-1:0]   word_in;
    logic                    word_we, tag_we, dirty_set, dirty_clr, dirty, use_valid;

    // read data goes to both ports, ack says who owns it
    assign ic_rsp = rsp;
    assign dc_rsp = rsp;

    l2_port_arbiter arb0 (.*);

    l2_main_fsm fsm0 (.*);

    l2_array array0 (.*);

    l2_plru plru0 (
        .clk        (clk),
        .rstn       (rstn),
        .index      (index),
        .use_valid  (use_valid),
        .use_way    (use_way),
        .valid_ways (valid_ways),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

//--- src/l2_main_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module l2_main_fsm (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    sel_req,
    input  l2_cache_pkg::l2_req_t   sel_in,
    output logic                    sel_ack,
    output l2_cache_pkg::l2_rsp_t   rsp,
    output logic                    mem_req,
    output l2_mem_pkg::mem_req_t    mem_out,
    input  logic                    mem_ack,
    input  l2_mem_pkg::mem_rsp_t    mem_in,
    output logic [`L2_INDEX_W-1:0]  index,
    output logic [`L2_TAG_W-1:0]    tag_in,
    output logic [`L2_WAY_W-1:0]    way_sel,
    output logic [`L2_WAYS-1:0]     data_we,
    output logic                    word_we,
    output logic [`L2_OFFSET_W-1:0] word_off,
    output logic [`L2_LINE_W-1:0]   line_in,
    output logic [`L2_WORD_W-1:0]   word_in,
    output logic                    tag_we,
    output logic [`L2_WAYS-1:0]     valid_clr,
    output logic                    dirty_set,
    output logic                    dirty_clr,
    input  logic [`L2_WAYS-1:0]     hit,
    input  logic                    dirty,
    input  logic [`L2_LINE_W-1:0]   line_out,
    input  logic [`L2_TAG_W-1:0]    tag_out,
    output logic                    use_valid,
    output logic [`L2_WAY_W-1:0]    use_way,
    input  logic [`L2_WAY_W-1:0]    victim_way
);

    l2_cache_pkg::l2_state_e state_q, state_d;
    l2_cache_pkg::l2_req_t   req_q;
    l2_cache_pkg::l2_rsp_t   rsp_q;

    logic [`L2_WAY_W-1:0]   tgt_way_q, hit_way, lookup_way;
    logic [`L2_WAYS-1:0]    way_oh;
    logic [`L2_INDEX_W-1:0] req_idx;
    logic [`L2_TAG_W-1:0]   req_tag;
    logic [`L2_WORD_W-1:0]  rsp_word;
    logic                   wb_done_q, hit_any, is_access, cap_rsp;

    assign req_idx   = req_q.addr[`L2_IDX_LSB +: `L2_INDEX_W];
    assign req_tag   = req_q.addr[`L2_ADDR_W-1 -: `L2_TAG_W];
    assign hit_any   = |hit;
    assign is_access = (req_q.op == l2_cache_pkg::OP_READ) ||
                       (req_q.op == l2_cache_pkg::OP_WRITE);

    always_comb begin
        hit_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (hit[w])
                hit_way = w[`L2_WAY_W-1:0];
        end
    end

    // target way chosen during lookup
    always_comb begin
        case (req_q.op)
            l2_cache_pkg::OP_IDX_INV,
            l2_cache_pkg::OP_IDX_WB_INV: lookup_way = req_q.addr[`L2_WAY_W-1:0];
            l2_cache_pkg::OP_HIT_WB_INV: lookup_way = hit_way;
            default:                     lookup_way = hit_any ? hit_way : victim_way;
        endcase
    end

    // first cycle reads the set of the incoming request
    assign index    = (state_q == l2_cache_pkg::S_IDLE) ?
                      sel_in.addr[`L2_IDX_LSB +: `L2_INDEX_W] : req_idx;
    assign tag_in   = req_tag;
    assign way_sel  = (state_q == l2_cache_pkg::S_LOOKUP) ? lookup_way : tgt_way_q;
    assign way_oh   = `L2_WAYS'(1) << way_sel;
    assign use_way  = way_sel;
    assign word_off = req_q.addr[2 +: `L2_OFFSET_W];
    assign word_in  = req_q.wdata;
    assign line_in  = mem_in.data;
    assign sel_ack  = (state_q == l2_cache_pkg::S_DONE);
    assign rsp      = rsp_q;

    // memory side, payload held by state and the stable set read
    assign mem_req = ((state_q == l2_cache_pkg::S_WRITEBACK) && !wb_done_q) ||
                     (state_q == l2_cache_pkg::S_REFILL);
    assign mem_out.write = (state_q == l2_cache_pkg::S_WRITEBACK);
    assign mem_out.addr  = mem_out.write ? {tag_out, req_idx} : {req_tag, req_idx};
    assign mem_out.data  = mem_out.write ? line_out : '0;

    ////////////////////////////////////////////////////////////////////////////
    // next state and array controls
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d   = state_q;
        data_we   = '0;
        word_we   = 1'b0;
        tag_we    = 1'b0;
        valid_clr = '0;
        dirty_set = 1'b0;
        dirty_clr = 1'b0;
        use_valid = 1'b0;
        cap_rsp   = 1'b0;
        rsp_word  = line_out[word_off*`L2_WORD_W +: `L2_WORD_W];
        case (state_q)
            l2_cache_pkg::S_IDLE: begin
                if (sel_req)
                    state_d = l2_cache_pkg::S_LOOKUP;
            end
            l2_cache_pkg::S_LOOKUP: begin
                state_d = l2_cache_pkg::S_DONE;
                if (req_q.op == l2_cache_pkg::OP_IDX_INV) begin
                    valid_clr = way_oh; // dirty data dropped
                    dirty_clr = 1'b1;
                end else if (is_access && hit_any) begin
                    use_valid = 1'b1;
                    if (req_q.op == l2_cache_pkg::OP_WRITE) begin
                        data_we   = way_oh;
                        word_we   = 1'b1;
                        dirty_set = 1'b1;
                    end else begin
                        cap_rsp = 1'b1;
                    end
                end else if (req_q.op != l2_cache_pkg::OP_HIT_WB_INV || hit_any) begin
                    state_d = l2_cache_pkg::S_CHECK_DIRTY;
                end
            end
            l2_cache_pkg::S_CHECK_DIRTY: begin
                if (dirty)
                    state_d = l2_cache_pkg::S_WRITEBACK;
                else if (is_access)
                    state_d = l2_cache_pkg::S_REFILL;
                else begin
                    valid_clr = way_oh;
                    state_d   = l2_cache_pkg::S_DONE;
                end
            end
            l2_cache_pkg::S_WRITEBACK: begin
                if (!wb_done_q && mem_ack)
                    dirty_clr = 1'b1;
                if (wb_done_q && !mem_ack) begin // four-phase closed
                    if (is_access)
                        state_d = l2_cache_pkg::S_REFILL;
                    else begin
                        valid_clr = way_oh;
                        state_d   = l2_cache_pkg::S_DONE;
                    end
                end
            end
            l2_cache_pkg::S_REFILL: begin
                if (mem_ack) begin
                    data_we   = way_oh;
                    tag_we    = 1'b1;
                    dirty_clr = 1'b1;
                    use_valid = 1'b1;
                    cap_rsp   = 1'b1;
                    rsp_word  = mem_in.data[word_off*`L2_WORD_W +: `L2_WORD_W];
                    state_d   = l2_cache_pkg::S_REFILL_WAIT;
                end
            end
            l2_cache_pkg::S_REFILL_WAIT: begin
                if (!mem_ack)
                    state_d = (req_q.op == l2_cache_pkg::OP_WRITE) ?
                              l2_cache_pkg::S_MERGE : l2_cache_pkg::S_DONE;
            end
            l2_cache_pkg::S_MERGE: begin
                data_we   = way_oh; // write-allocate word
                word_we   = 1'b1;
                dirty_set = 1'b1;
                state_d   = l2_cache_pkg::S_DONE;
            end
            l2_cache_pkg::S_DONE: begin
                if (!sel_req)
                    state_d = l2_cache_pkg::S_IDLE;
            end
            default: state_d = l2_cache_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q   <= l2_cache_pkg::S_IDLE;
            wb_done_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q != l2_cache_pkg::S_WRITEBACK)
                wb_done_q <= 1'b0;
            else if (mem_ack)
                wb_done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == l2_cache_pkg::S_IDLE && sel_req)
            req_q <= sel_in;
        if (state_q == l2_cache_pkg::S_LOOKUP)
            tgt_way_q <= lookup_way;
        if (cap_rsp)
            rsp_q.rdata <= rsp_word;
    end

endmodule

`default_nettype wire

//--- src/l2_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module l2_array (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [`L2_INDEX_W-1:0]   index,
    input  logic [`L2_TAG_W-1:0]     tag_in,
    input  logic [`L2_WAY_W-1:0]     way_sel,
    input  logic [`L2_WAYS-1:0]      data_we,
    input  logic                     word_we,
    input  logic [`L2_OFFSET_W-1:0]  word_off,
    input  logic [`L2_LINE_W-1:0]    line_in,
    input  logic [`L2_WORD_W-1:0]    word_in,
    input  logic                     tag_we,
    input  logic [`L2_WAYS-1:0]      valid_clr,
    input  logic                     dirty_set,
    input  logic                     dirty_clr,
    output logic [`L2_WAYS-1:0]      hit,
    output logic [`L2_WAYS-1:0]      valid_ways,
    output logic                     dirty,
    output logic [`L2_LINE_W-1:0]    line_out,
    output logic [`L2_TAG_W-1:0]     tag_out
);

    logic [`L2_TAG_W-1:0]  tag_q  [`L2_SETS][`L2_WAYS];
    logic [`L2_LINE_W-1:0] data_q [`L2_SETS][`L2_WAYS];
    logic [`L2_WAYS-1:0]   valid_q [`L2_SETS];
    logic [`L2_WAYS-1:0]   dirty_q [`L2_SETS];

    // registered copy of the indexed set
    logic [`L2_TAG_W-1:0]  rd_tag  [`L2_WAYS];
    logic [`L2_LINE_W-1:0] rd_line [`L2_WAYS];
    logic [`L2_WAYS-1:0]   rd_valid;

    logic [`L2_WAYS-1:0]   way_oh;

    assign way_oh = `L2_WAYS'(1) << way_sel;

    ////////////////////////////////////////////////////////////////////////////
    // tag and data store
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (data_we[w]) begin
                if (word_we)
                    data_q[index][w][word_off*`L2_WORD_W +: `L2_WORD_W] <= word_in;
                else
                    data_q[index][w] <= line_in; // full refill
            end
            rd_tag[w]  <= tag_q[index][w];
            rd_line[w] <= data_q[index][w];
        end
        if (tag_we)
            tag_q[index][way_sel] <= tag_in;
    end

    ////////////////////////////////////////////////////////////////////////////
    // valid and dirty
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q  <= '{default: '0};
            dirty_q  <= '{default: '0};
            rd_valid <= '0;
        end else begin
            valid_q[index] <= (valid_q[index] & ~valid_clr) | (tag_we ? way_oh : '0);
            if (dirty_set)
                dirty_q[index][way_sel] <= 1'b1;
            else if (dirty_clr)
                dirty_q[index][way_sel] <= 1'b0;
            rd_valid <= valid_q[index];
        end
    end

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++)
            hit[w] = rd_valid[w] && (rd_tag[w] == tag_in);
    end

    assign valid_ways = rd_valid;
    assign dirty      = dirty_q[index][way_sel];
    assign line_out   = rd_line[way_sel];
    assign tag_out    = rd_tag[way_sel];

endmodule

`default_nettype wire

//--- src/l2_plru.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module l2_plru (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`L2_INDEX_W-1:0]  index,
    input  logic                    use_valid,
    input  logic [`L2_WAY_W-1:0]    use_way,
    input  logic [`L2_WAYS-1:0]     valid_ways,
    output logic [`L2_WAY_W-1:0]    victim_way
);

    // bit 0 root (1 = right pair), bit 1 left pair, bit 2 right pair
    logic [2:0] tree_q [`L2_SETS];
    logic [2:0] tree;

    assign tree = tree_q[index];

    always_comb begin
        victim_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!valid_ways[w])
                victim_way = w[`L2_WAY_W-1:0]; // lowest free way wins
        end
    end

    // point away from the used way
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tree_q <= '{default: '0};
        end else if (use_valid) begin
            tree_q[index][0] <= ~use_way[1];
            if (use_way[1])
                tree_q[index][2] <= ~use_way[0];
            else
                tree_q[index][1] <= ~use_way[0];
        end
    end

endmodule

`default_nettype wire

//--- src/l2_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module l2_port_arbiter (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ic_req,
    input  logic                  dc_req,
    input  l2_cache_pkg::l2_req_t ic_in,
    input  l2_cache_pkg::l2_req_t dc_in,
    output logic                  ic_ack,
    output logic                  dc_ack,
    output logic                  sel_req,
    output l2_cache_pkg::l2_req_t sel_in,
    input  logic                  sel_ack
);

    logic busy_q;     // transaction open
    logic gnt_dc_q;   // granted port, 1 = data
    logic last_dc_q;  // last winner, reset value lets data win first
    logic pick_dc;
    logic use_dc;

    // round robin only matters on a tie
    assign pick_dc = (ic_req && dc_req) ? !last_dc_q : dc_req;
    assign use_dc  = busy_q ? gnt_dc_q : pick_dc;

    assign sel_req = use_dc ? dc_req : ic_req;
    assign sel_in  = use_dc ? dc_in : ic_in;

    assign ic_ack = sel_ack && !use_dc;
    assign dc_ack = sel_ack && use_dc;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy_q    <= 1'b0;
            gnt_dc_q  <= 1'b0;
            last_dc_q <= 1'b0;
        end else if (!busy_q) begin
            if (ic_req || dc_req) begin
                busy_q    <= 1'b1;
                gnt_dc_q  <= pick_dc;
                last_dc_q <= pick_dc;
            end
        end else if (!sel_req && !sel_ack) begin
            busy_q <= 1'b0; // handshake fully closed
        end
    end

endmodule

`default_nettype wire

//--- src/l2_mem_pkg.sv
`default_nettype none

`include "l2_params.svh"

package l2_mem_pkg;

    // one line per transaction, write flag picks the direction
    typedef struct packed {
        logic                                 write;
        logic [`L2_TAG_W+`L2_INDEX_W-1:0]     addr;  // tag and index
        logic [`L2_LINE_W-1:0]                data;
    } mem_req_t;

    typedef struct packed {
        logic [`L2_LINE_W-1:0]                data;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- src/l2_cache_pkg.sv
`default_nettype none

`include "l2_params.svh"

package l2_cache_pkg;

    // request opcodes
    typedef enum logic [2:0] {
        OP_READ       = 3'd0,
        OP_WRITE      = 3'd1,
        OP_IDX_INV    = 3'd2, // way from addr[1:0]
        OP_IDX_WB_INV = 3'd3, // way from addr[1:0]
        OP_HIT_WB_INV = 3'd4
    } l2_op_e;

    typedef struct packed {
        l2_op_e                 op;
        logic [`L2_ADDR_W-1:0]  addr;  // byte address
        logic [`L2_WORD_W-1:0]  wdata;
    } l2_req_t;

    typedef struct packed {
        logic [`L2_WORD_W-1:0]  rdata;
    } l2_rsp_t;

    // controller states
    typedef enum logic [3:0] {
        S_IDLE,
        S_LOOKUP,
        S_OPERATE,
        S_CHECK_DIRTY,
        S_WRITEBACK,
        S_REFILL,
        S_REFILL_WAIT,
        S_MERGE,
        S_DONE
    } l2_state_e;

endpackage

`default_nettype wire

//--- src/l2_params.svh
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// cache geometry
`define L2_WAYS     4
`define L2_WAY_W    2
`define L2_INDEX_W  4
`define L2_SETS     16
`define L2_OFFSET_W 2

// widths
`define L2_ADDR_W   32
`define L2_WORD_W   32
`define L2_LINE_W   128
`define L2_TAG_W    24

// index sits above the word offset and the byte bits
`define L2_IDX_LSB  (`L2_OFFSET_W + 2)

`endif
